// File: hw/interruptController.sv
`timescale 1ns/1ps
`default_nettype none

module interruptController(
    input   logic                                   clk,
    input   logic                                   arstN,
    input   logic   [intrPkg::NUM_SOURCES-1:0]      triggerInterrupt,
    input   logic   [intrPkg::VECTOR_WIDTH-1:0]     interruptIn,
    input   logic                                   interruptAcknowledge,

    output  logic   [intrPkg::VECTOR_WIDTH-1:0]     interruptOut,
    output  logic                                   interruptRequest
    );

    import intrPkg::*;

    logic   [NUM_SOURCES-1:0]   resetInterrupt;
    logic   [NUM_SOURCES-1:0]   triggeredInterrupts;

    interruptState interruptState_inst(
        .clk                    (clk),
        .arstN                  (arstN),
        .triggerInterrupt       (triggerInterrupt),
        .resetInterrupt         (resetInterrupt),
        .triggeredInterrupts    (triggeredInterrupts)
    );

    // the acknowledged vector becomes a one-hot clear for the pending flags
    always_comb begin
        resetInterrupt = '0;

        if (interruptAcknowledge) begin
            resetInterrupt[interruptIn] = 1'b1;
        end
    end

    // lowest number wins, so the scan runs from the top down and the last hit sticks
    always_comb begin
        interruptRequest = |triggeredInterrupts;
        interruptOut     = '0;

        for (int i = NUM_SOURCES - 1; i >= 0; i--) begin
            if (triggeredInterrupts[i]) begin
                interruptOut = VECTOR_WIDTH'(i);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/interruptDispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module interruptDispatcher(
    input   logic                                   clk,
    input   logic                                   arstN,
    input   logic                                   interruptRequest,
    input   logic   [intrPkg::VECTOR_WIDTH-1:0]     interruptOut,
    input   logic                                   cpuAck,

    output  logic                                   interruptAcknowledge,
    output  logic   [intrPkg::VECTOR_WIDTH-1:0]     interruptIn,
    output  logic                                   cpuIrq,
    output  logic   [intrPkg::VECTOR_WIDTH-1:0]     cpuVector
    );

    import intrPkg::*;

    dispatchState_t             state;
    dispatchState_t             nextState;
    logic   [VECTOR_WIDTH-1:0]  latchedVector;

    always_comb begin
        nextState = state;

        case (state)
            IDLE: begin
                if (interruptRequest) begin
                    nextState = PENDING;
                end
            end
            PENDING: begin
                if (cpuAck) begin
                    nextState = IDLE;  // the next vector can be taken one cycle later
                end
            end
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // the vector is frozen while PENDING so newer arrivals only wait as pending bits
    always_ff @(posedge clk) begin
        if (state == IDLE && interruptRequest) begin
            latchedVector <= interruptOut;
        end
    end

    always_comb begin
        cpuIrq               = (state == PENDING);
        cpuVector            = latchedVector;
        interruptAcknowledge = (state == PENDING) && cpuAck;  // a stray cpuAck in IDLE is ignored
        interruptIn          = latchedVector;
    end

endmodule

`default_nettype wire

// File: hw/interruptSources.sv
`timescale 1ns/1ps
`default_nettype none

module interruptSources(
    input   logic                               clk,
    input   logic                               arstN,
    input   logic   [intrPkg::NUM_SOURCES-1:0]  sourceLines,
    input   logic                               maskWrite,
    input   logic   [intrPkg::NUM_SOURCES-1:0]  maskData,

    output  logic   [intrPkg::NUM_SOURCES-1:0]  triggerInterrupt
    );

    import intrPkg::*;

    logic   [NUM_SOURCES-1:0]   syncStage1;
    logic   [NUM_SOURCES-1:0]   syncStage2;
    logic   [NUM_SOURCES-1:0]   lineHistory;
    logic   [NUM_SOURCES-1:0]   maskReg;
    logic   [NUM_SOURCES-1:0]   risingEdge;

    // two flops per line bring the raw levels into the clock domain
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            syncStage1 <= '0;
            syncStage2 <= '0;
        end else begin
            syncStage1 <= sourceLines;
            syncStage2 <= syncStage1;
        end
    end

    // history starts at zero so a line that is high out of reset still makes an edge
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lineHistory <= '0;
        end else begin
            lineHistory <= syncStage2;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            maskReg <= '1;  // every source is enabled after reset
        end else if (maskWrite) begin
            maskReg <= maskData;
        end
    end

    always_comb begin
        risingEdge = syncStage2 & ~lineHistory;  // high for exactly one cycle per low to high step
    end

    // a masked edge is dropped here and is not remembered anywhere
    always_comb begin
        triggerInterrupt = risingEdge & maskReg;
    end

endmodule

`default_nettype wire

// File: hw/interruptState.sv
`timescale 1ns/1ps
`default_nettype none

module interruptState(
    input   logic                               clk,
    input   logic                               arstN,
    input   logic   [intrPkg::NUM_SOURCES-1:0]  triggerInterrupt,
    input   logic   [intrPkg::NUM_SOURCES-1:0]  resetInterrupt,

    output  logic   [intrPkg::NUM_SOURCES-1:0]  triggeredInterrupts
    );

    import intrPkg::*;

    logic   [NUM_SOURCES-1:0]   nextPending;

    // the set term is applied last so a fresh edge survives a clear in the same cycle
    always_comb begin
        nextPending = (triggeredInterrupts & ~resetInterrupt) | triggerInterrupt;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            triggeredInterrupts <= '0;
        end else begin
            triggeredInterrupts <= nextPending;
        end
    end

endmodule

`default_nettype wire

// File: hw/interruptSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module interruptSubsystem(
    input   logic                                   clk,
    input   logic                                   arstN,
    input   logic   [intrPkg::NUM_SOURCES-1:0]      sourceLines,
    input   logic                                   maskWrite,
    input   logic   [intrPkg::NUM_SOURCES-1:0]      maskData,
    input   logic                                   cpuAck,

    output  logic                                   cpuIrq,
    output  logic   [intrPkg::VECTOR_WIDTH-1:0]     cpuVector
    );

    import intrPkg::*;

    logic   [NUM_SOURCES-1:0]   triggerInterrupt;
    logic                       interruptRequest;
    logic   [VECTOR_WIDTH-1:0]  interruptOut;
    logic                       interruptAcknowledge;
    logic   [VECTOR_WIDTH-1:0]  interruptIn;

    interruptSources interruptSources_inst(
        .clk                    (clk),
        .arstN                  (arstN),
        .sourceLines            (sourceLines),
        .maskWrite              (maskWrite),
        .maskData               (maskData),
        .triggerInterrupt       (triggerInterrupt)
    );

    interruptController interruptController_inst(
        .clk                    (clk),
        .arstN                  (arstN),
        .triggerInterrupt       (triggerInterrupt),
        .interruptIn            (interruptIn),
        .interruptAcknowledge   (interruptAcknowledge),
        .interruptOut           (interruptOut),
        .interruptRequest       (interruptRequest)
    );

    // the dispatcher closes the loop by feeding the served vector back as a clear
    interruptDispatcher interruptDispatcher_inst(
        .clk                    (clk),
        .arstN                  (arstN),
        .interruptRequest       (interruptRequest),
        .interruptOut           (interruptOut),
        .cpuAck                 (cpuAck),
        .interruptAcknowledge   (interruptAcknowledge),
        .interruptIn            (interruptIn),
        .cpuIrq                 (cpuIrq),
        .cpuVector              (cpuVector)
    );

endmodule

`default_nettype wire

// File: hw/intrPkg.sv
`default_nettype none

package intrPkg;

    // number of peripheral interrupt lines handled by the subsystem
    localparam int NUM_SOURCES = 16;

    // a source number fits in this many bits
    localparam int VECTOR_WIDTH = 4;

    typedef enum logic {
        IDLE,    // no vector shown to the CPU
        PENDING  // vector latched and waiting for cpuAck
    } dispatchState_t;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

TOP=interruptSubsystemTb
BUILD_DIR=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found on the PATH"
    exit 1
fi

verilator --binary --timing \
    --timescale 1ns/1ps \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "compile step failed with status $status"
    exit 1
fi

output=$("./$BUILD_DIR/V$TOP")
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "SIMULATION PASSED"; then
    exit 0
fi

echo "pass message not found in the simulation output"
exit 1

// File: tests/interruptSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module interruptSubsystemTb;

    import intrPkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_FIXED       = 6;
    localparam int NUM_RANDOM      = 6;
    localparam int NUM_ENTRIES     = NUM_FIXED + NUM_RANDOM;
    localparam int IRQ_WAIT_LIMIT  = 10;
    localparam int DIRECTED_CYCLES = 120;  // room for the reset, latency and back-pressure tests

    logic                               clk;
    logic                               arstN;
    logic   [NUM_SOURCES-1:0]           sourceLines;
    logic                               maskWrite;
    logic   [NUM_SOURCES-1:0]           maskData;
    logic                               cpuAck;
    logic                               cpuIrq;
    logic   [VECTOR_WIDTH-1:0]          cpuVector;

    logic   [NUM_SOURCES-1:0]               maskTable [NUM_ENTRIES];
    logic   [NUM_SOURCES-1:0]               patternTable [NUM_ENTRIES];
    logic   [NUM_SOURCES*VECTOR_WIDTH-1:0]  vectorTable [NUM_ENTRIES];  // nibble k is served k-th
    int                                     countTable [NUM_ENTRIES];

    logic   [31:0]  lfsrState;
    logic           tableReady;
    int             budgetCycles;
    int             errorCount;
    int             testCount;
    int             failedTests;
    int             testStartErrors;

    interruptSubsystem interruptSubsystem_inst(
        .clk            (clk),
        .arstN          (arstN),
        .sourceLines    (sourceLines),
        .maskWrite      (maskWrite),
        .maskData       (maskData),
        .cpuAck         (cpuAck),
        .cpuIrq         (cpuIrq),
        .cpuVector      (cpuVector)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // taps for x^32 + x^22 + x^2 + x + 1, the fresh bit enters at the bottom
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeRandom(output logic [NUM_SOURCES-1:0] value);
        value = '0;
        for (int i = 0; i < NUM_SOURCES; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[NUM_SOURCES-2:0], lfsrState[0]};
        end
    endtask

    // enabled edges are served from source 0 upward
    task automatic serviceOrder(input logic [NUM_SOURCES-1:0] bits,
                                output logic [NUM_SOURCES*VECTOR_WIDTH-1:0] vectors,
                                output int count);
        vectors = '0;
        count = 0;
        for (int i = 0; i < NUM_SOURCES; i++) begin
            if (bits[i]) begin
                vectors[VECTOR_WIDTH*count +: VECTOR_WIDTH] = VECTOR_WIDTH'(i);
                count++;
            end
        end
    endtask

    task automatic setRow(input int e, input logic [NUM_SOURCES-1:0] mask,
                          input logic [NUM_SOURCES-1:0] pattern, input int count,
                          input logic [NUM_SOURCES*VECTOR_WIDTH-1:0] vectors);
        maskTable[e]    = mask;
        patternTable[e] = pattern;
        countTable[e]   = count;
        vectorTable[e]  = vectors;
    endtask

    task automatic buildTable();
        logic [NUM_SOURCES-1:0]             mask;
        logic [NUM_SOURCES-1:0]             pattern;
        logic [NUM_SOURCES*VECTOR_WIDTH-1:0] vectors;
        int                                 count;

        setRow(0, 16'hffff, 16'h0008, 1, 64'h3);
        setRow(1, 16'hffff, 16'h8421, 4, 64'hfa50);
        setRow(2, 16'h00ff, 16'h0f0f, 4, 64'h3210);
        setRow(3, 16'hfffe, 16'h0003, 1, 64'h1);  // source 0 is masked, source 1 is not
        setRow(4, 16'h0000, 16'hffff, 0, 64'h0);
        setRow(5, 16'hffff, 16'hc000, 2, 64'hfe);
        for (int e = NUM_FIXED; e < NUM_ENTRIES; e++) begin
            takeRandom(mask);
            takeRandom(pattern);
            serviceOrder(pattern & mask, vectors, count);
            setRow(e, mask, pattern, count, vectors);
        end
        budgetCycles = DIRECTED_CYCLES;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            budgetCycles += 10 * countTable[e] + 20;
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic reportProblem(input string what);
        $display("problem at %0t ns: %s", $time, what);
        errorCount++;
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (errorCount == testStartErrors) begin
            $display("test %0d %s: ok", testCount, name);
        end else begin
            failedTests++;
            $display("test %0d %s: %0d error(s)", testCount, name, errorCount - testStartErrors);
        end
        testStartErrors = errorCount;
    endtask

    task automatic writeMask(input logic [NUM_SOURCES-1:0] mask);
        maskWrite = 1'b1;
        maskData  = mask;
        @(negedge clk);
        maskWrite = 1'b0;
    endtask

    task automatic pulseLines(input logic [NUM_SOURCES-1:0] pattern, input int holdCycles);
        sourceLines = pattern;
        repeat (holdCycles) @(negedge clk);
        sourceLines = '0;
    endtask

    task automatic waitForIrq(output int cycles);
        cycles = 0;
        while (!cpuIrq && cycles < IRQ_WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!cpuIrq) begin
            reportProblem("cpuIrq never rose while a vector was expected");
        end
    endtask

    // cpuIrq drops at the same edge that samples the acknowledge
    task automatic acknowledge();
        cpuAck = 1'b1;
        @(negedge clk);
        cpuAck = 1'b0;
        checkValue("cpuIrq", 32'(cpuIrq), 32'd0);
    endtask

    task automatic expectQuiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            checkValue("cpuIrq", 32'(cpuIrq), 32'd0);
        end
    endtask

    task automatic latencyAndEdgeTest();
        int edges;
        int cycles;

        sourceLines = 16'h0040;  // the mask still holds its all-ones value from reset
        edges = 0;
        while (!cpuIrq && edges < IRQ_WAIT_LIMIT) begin
            @(negedge clk);
            edges++;  // each falling edge follows one rising edge, the first one samples
        end
        checkValue("rising edges to cpuIrq", 32'(edges), 32'd4);
        checkValue("cpuVector", 32'(cpuVector), 32'd6);
        acknowledge();
        finishTest("latency");
        expectQuiet(8);  // line 6 is still held high here
        sourceLines = '0;
        repeat (3) @(negedge clk);
        sourceLines = 16'h0040;
        waitForIrq(cycles);
        checkValue("cpuVector", 32'(cpuVector), 32'd6);
        acknowledge();
        sourceLines = '0;
        expectQuiet(6);
        finishTest("edge only");
    endtask

    task automatic backPressureTest();
        int cycles;

        writeMask(16'hffff);
        pulseLines(16'h0200, 2);
        waitForIrq(cycles);
        checkValue("cpuVector", 32'(cpuVector), 32'd9);
        pulseLines(16'h0004, 2);
        repeat (6) begin
            @(negedge clk);
            checkValue("cpuIrq", 32'(cpuIrq), 32'd1);
            checkValue("cpuVector", 32'(cpuVector), 32'd9);  // source 2 waits as a pending bit
        end
        acknowledge();
        waitForIrq(cycles);
        checkValue("cycles to next cpuIrq", 32'(cycles), 32'd1);
        checkValue("cpuVector", 32'(cpuVector), 32'd2);
        acknowledge();
        expectQuiet(6);
        finishTest("back-pressure");
    endtask

    task automatic runEntry(input int e);
        int cycles;

        writeMask(maskTable[e]);
        pulseLines(patternTable[e], 2);
        for (int k = 0; k < countTable[e]; k++) begin
            waitForIrq(cycles);
            if (k > 0) begin
                checkValue("cycles to next cpuIrq", 32'(cycles), 32'd1);
            end
            checkValue("cpuVector", 32'(cpuVector),
                       32'(vectorTable[e][VECTOR_WIDTH*k +: VECTOR_WIDTH]));
            acknowledge();
        end
        expectQuiet(6);
    endtask

    initial begin
        arstN           = 1'b0;
        sourceLines     = '0;
        maskWrite       = 1'b0;
        maskData        = '0;
        cpuAck          = 1'b0;
        errorCount      = 0;
        testCount       = 0;
        failedTests     = 0;
        testStartErrors = 0;
        lfsrState       = 32'd85282;
        tableReady      = 1'b0;
        buildTable();
        tableReady = 1'b1;
        repeat (2) @(negedge clk);
        arstN = 1'b1;
        expectQuiet(4);
        finishTest("reset");
        latencyAndEdgeTest();
        backPressureTest();
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            runEntry(e);
            finishTest($sformatf("table entry %0d", e));
        end
        $display("%0d tests run, %0d with errors, %0d errors in total",
                 testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        wait (tableReady === 1'b1);
        repeat (budgetCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles before the tests completed", budgetCycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hw/intrPkg.sv
hw/interruptSources.sv
hw/interruptState.sv
hw/interruptController.sv
hw/interruptDispatcher.sv
hw/interruptSubsystem.sv
tests/interruptSubsystemTb.sv
